//--- Bender.yml
package:
  name: rip_mem_subsys

sources:
  - design/rip_const.sv
  - design/rip_type.sv
  - design/rip_decode.sv
  - design/rip_execute.sv
  - design/rip_memory_access.sv
  - design/rip_dual_port_ram.sv
  - design/rip_result.sv
  - design/rip_mem_subsys.sv
  - target: test
    files:
      - test/rip_mem_subsys_tb.sv

//--- design/rip_const.sv
// widths and memory depth of the load/store path
// RV32I major opcodes and funct3 access-size codes

`default_nettype none

package rip_const;

    localparam int DATA_WIDTH = 32;           // one word
    localparam int B_WIDTH    = 8;            // one byte lane
    localparam int NUM_COL    = DATA_WIDTH / B_WIDTH;
    localparam int MEM_WORDS  = 256;
    localparam int ADDR_WIDTH = $clog2(MEM_WORDS);  // word index, addr[9:2]
    localparam int RD_WIDTH   = 5;            // register index

    localparam logic [6:0] OPC_LOAD  = 7'b0000011;
    localparam logic [6:0] OPC_STORE = 7'b0100011;

    localparam logic [2:0] F3_B  = 3'b000;
    localparam logic [2:0] F3_H  = 3'b001;
    localparam logic [2:0] F3_W  = 3'b010;
    localparam logic [2:0] F3_BU = 3'b100;
    localparam logic [2:0] F3_HU = 3'b101;

endpackage : rip_const

`default_nettype wire

//--- design/rip_decode.sv
// load/store decoder
// instruction word to flags, sign-extended I/S immediate and rd

`default_nettype none
`timescale 1ns/1ns

module rip_decode (
    input  wire  [rip_const::DATA_WIDTH-1:0] inst_word,
    output rip_type::inst_t                  inst,
    output logic [rip_const::DATA_WIDTH-1:0] imm,
    output logic [rip_const::RD_WIDTH-1:0]   rd
);
    import rip_const::*;

    logic [6:0]            opcode;
    logic [2:0]            funct3;
    logic [DATA_WIDTH-1:0] i_imm;
    logic [DATA_WIDTH-1:0] s_imm;

    assign opcode = inst_word[6:0];
    assign funct3 = inst_word[14:12];
    assign rd     = inst_word[11:7];

    assign i_imm = {{(DATA_WIDTH-12){inst_word[31]}}, inst_word[31:20]};
    assign s_imm = {{(DATA_WIDTH-12){inst_word[31]}}, inst_word[31:25], inst_word[11:7]};

    always_comb begin
        inst = '0;                               // non-memory ops decode to nothing
        case (opcode)
            OPC_LOAD: begin
                case (funct3)
                    F3_B:    inst.lb  = 1'b1;
                    F3_H:    inst.lh  = 1'b1;
                    F3_W:    inst.lw  = 1'b1;
                    F3_BU:   inst.lbu = 1'b1;
                    F3_HU:   inst.lhu = 1'b1;
                    default: inst = '0;          // reserved funct3
                endcase
            end
            OPC_STORE: begin
                case (funct3)
                    F3_B:    inst.sb = 1'b1;
                    F3_H:    inst.sh = 1'b1;
                    F3_W:    inst.sw = 1'b1;
                    default: inst = '0;
                endcase
            end
            default: inst = '0;
        endcase
    end

    assign imm = (opcode == OPC_STORE) ? s_imm : i_imm;

endmodule : rip_decode

`default_nettype wire

//--- design/rip_dual_port_ram.sv
// word RAM, byte-lane write/read port 1 and read-only fetch port 2
// both reads registered, outputs hold while not enabled

`default_nettype none
`timescale 1ns/1ns

module rip_dual_port_ram (
    input  wire                               clk,
    input  wire  [rip_const::NUM_COL-1:0]     we_1,
    input  wire                               re_1,
    input  wire  [rip_const::ADDR_WIDTH-1:0]  addr_1,
    input  wire  [rip_const::DATA_WIDTH-1:0]  din_1,
    output logic [rip_const::DATA_WIDTH-1:0]  dout_1,
    input  wire                               re_2,
    input  wire  [rip_const::ADDR_WIDTH-1:0]  addr_2,
    output logic [rip_const::DATA_WIDTH-1:0]  dout_2
);
    import rip_const::*;

    logic [NUM_COL-1:0][B_WIDTH-1:0] mem [MEM_WORDS];

    always_ff @(posedge clk) begin
        for (int i = 0; i < NUM_COL; i++) begin
            if (we_1[i]) begin
                mem[addr_1][i] <= din_1[i*B_WIDTH +: B_WIDTH];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (re_1) begin
            dout_1 <= mem[addr_1];
        end
        if (re_2) begin
            dout_2 <= mem[addr_2];               // fetch
        end
    end

endmodule : rip_dual_port_ram

`default_nettype wire

//--- design/rip_execute.sv
// execute stage
// effective address add and ex stage register

`default_nettype none
`timescale 1ns/1ns

module rip_execute (
    input  wire                               clk,
    input  wire                               rst,
    input  wire                               cmd_valid,
    input  wire                               stall,
    input  wire rip_type::inst_t              inst,
    input  wire [rip_const::DATA_WIDTH-1:0]   imm,
    input  wire [rip_const::DATA_WIDTH-1:0]   rs1,
    input  wire [rip_const::DATA_WIDTH-1:0]   rs2,
    input  wire [rip_const::RD_WIDTH-1:0]     rd,
    output rip_type::ex_stage_t               ex
);
    import rip_const::*;

    logic [DATA_WIDTH-1:0] eff_addr;
    logic                  accept;

    assign eff_addr = rs1 + imm;
    assign accept   = cmd_valid && !stall && (|inst);   // drop non-memory ops

    always_ff @(posedge clk) begin
        if (rst) begin
            ex.valid <= 1'b0;
        end else if (!stall) begin
            ex.valid <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            ex.inst <= inst;
            ex.addr <= eff_addr;
            ex.din  <= rs2;
            ex.rd   <= rd;
        end
    end

    // the source holds off while the pipe is frozen
    a_no_cmd_in_stall : assert property (@(posedge clk) disable iff (rst) stall |-> !cmd_valid)
        else $error("command strobed while stall is high");

endmodule : rip_execute

`default_nettype wire

//--- design/rip_mem_subsys.sv
// load/store memory subsystem top
// decode, execute, memory access, dual-port RAM and result stage

`default_nettype none
`timescale 1ns/1ns

module rip_mem_subsys (
    input  wire                               clk,
    input  wire                               rst,
    input  wire                               cmd_valid,
    input  wire  [rip_const::DATA_WIDTH-1:0]  cmd_inst,
    input  wire  [rip_const::DATA_WIDTH-1:0]  cmd_rs1,
    input  wire  [rip_const::DATA_WIDTH-1:0]  cmd_rs2,
    input  wire                               stall,
    input  wire                               if_ready,
    input  wire  [rip_const::DATA_WIDTH-1:0]  pc,
    output logic [rip_const::DATA_WIDTH-1:0]  if_dout,
    output logic                              load_valid,
    output rip_type::load_result_t            load_result
);
    import rip_const::*;
    import rip_type::*;

    inst_t                  dec_inst;
    logic [DATA_WIDTH-1:0]  dec_imm;
    logic [RD_WIDTH-1:0]    dec_rd;
    ex_stage_t              ex;
    ma_stage_t              ma;
    logic [NUM_COL-1:0]     we_1;
    logic                   re_1;
    logic                   re_2;
    logic [ADDR_WIDTH-1:0]  addr_1;
    logic [ADDR_WIDTH-1:0]  addr_2;
    logic [DATA_WIDTH-1:0]  din_1;
    logic [DATA_WIDTH-1:0]  dout_1;
    logic [DATA_WIDTH-1:0]  dout_2;
    logic [DATA_WIDTH-1:0]  ma_dout;

    rip_decode rip_decode_i (
        .inst_word (cmd_inst),
        .inst      (dec_inst),
        .imm       (dec_imm),
        .rd        (dec_rd)
    );

    rip_execute rip_execute_i (
        .clk       (clk),
        .rst       (rst),
        .cmd_valid (cmd_valid),
        .stall     (stall),
        .inst      (dec_inst),
        .imm       (dec_imm),
        .rs1       (cmd_rs1),
        .rs2       (cmd_rs2),
        .rd        (dec_rd),
        .ex        (ex)
    );

    rip_memory_access rip_memory_access_i (
        .stall     (stall),
        .ex        (ex),
        .ma        (ma),
        .we_1      (we_1),
        .re_1      (re_1),
        .addr_1    (addr_1),
        .din_1     (din_1),
        .dout_1    (dout_1),
        .if_ready  (if_ready),
        .re_2      (re_2),
        .pc        (pc),
        .addr_2    (addr_2),
        .dout_2    (dout_2),
        .if_dout   (if_dout),
        .ma_dout   (ma_dout)
    );

    rip_dual_port_ram rip_dual_port_ram_i (
        .clk       (clk),
        .we_1      (we_1),
        .re_1      (re_1),
        .addr_1    (addr_1),
        .din_1     (din_1),
        .dout_1    (dout_1),
        .re_2      (re_2),
        .addr_2    (addr_2),
        .dout_2    (dout_2)
    );

    rip_result rip_result_i (
        .clk         (clk),
        .rst         (rst),
        .stall       (stall),
        .ex          (ex),
        .ma          (ma),
        .ma_dout     (ma_dout),
        .load_valid  (load_valid),
        .load_result (load_result)
    );

endmodule : rip_mem_subsys

`default_nettype wire

//--- design/rip_memory_access.sv
// byte-addressed memory access
// byte enables, store shift, read enable, fetch port and load extraction

`default_nettype none
`timescale 1ns/1ns

module rip_memory_access (
    input  wire                               stall,
    input  wire rip_type::ex_stage_t          ex,
    input  wire rip_type::ma_stage_t          ma,
    output logic [rip_const::NUM_COL-1:0]     we_1,
    output logic                              re_1,
    output logic [rip_const::ADDR_WIDTH-1:0]  addr_1,
    output logic [rip_const::DATA_WIDTH-1:0]  din_1,
    input  wire  [rip_const::DATA_WIDTH-1:0]  dout_1,
    input  wire                               if_ready,
    output logic                              re_2,
    input  wire  [rip_const::DATA_WIDTH-1:0]  pc,
    output logic [rip_const::ADDR_WIDTH-1:0]  addr_2,
    input  wire  [rip_const::DATA_WIDTH-1:0]  dout_2,
    output logic [rip_const::DATA_WIDTH-1:0]  if_dout,
    output logic [rip_const::DATA_WIDTH-1:0]  ma_dout
);
    import rip_const::*;

    logic [1:0]            ex_off;
    logic [1:0]            ma_off;
    logic                  ex_go;
    logic [DATA_WIDTH-1:0] byte_word;
    logic [DATA_WIDTH-1:0] half_word;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // fetch port
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign re_2    = if_ready;
    assign addr_2  = pc[ADDR_WIDTH+1:2];         // low bits dropped
    assign if_dout = dout_2;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // port 1 command from the ex stage
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign ex_off = ex.addr[1:0];
    assign ex_go  = ex.valid && !stall;
    assign addr_1 = ex.addr[ADDR_WIDTH+1:2];     // wraps above MEM_WORDS
    assign re_1   = ex_go && (ex.inst.lb || ex.inst.lh || ex.inst.lw ||
                              ex.inst.lbu || ex.inst.lhu);

    always_comb begin
        logic [1:0] lane;
        for (int i = 0; i < NUM_COL; i++) begin
            lane    = 2'(i);
            we_1[i] = ex_go && ((ex.inst.sb && ex_off == lane) ||
                                (ex.inst.sh && ex_off[1] == lane[1]) ||
                                ex.inst.sw);
        end
    end

    always_comb begin
        if (ex.inst.sb) begin
            din_1 = {{(DATA_WIDTH-B_WIDTH){1'b0}}, ex.din[B_WIDTH-1:0]} << (ex_off * B_WIDTH);
        end else if (ex.inst.sh) begin
            din_1 = {{(DATA_WIDTH/2){1'b0}}, ex.din[DATA_WIDTH/2-1:0]} << (ex_off * B_WIDTH);
        end else begin
            din_1 = ex.din;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // load extraction from the registered read word
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign ma_off    = ma.addr[1:0];
    assign byte_word = dout_1 >> (ma_off * B_WIDTH);
    assign half_word = dout_1 >> ((ma_off[1] ? 2'd2 : ma_off) * B_WIDTH);  // off 1 -> [23:8]

    always_comb begin
        if (ma.inst.lb) begin
            ma_dout = {{(DATA_WIDTH-B_WIDTH){byte_word[B_WIDTH-1]}}, byte_word[B_WIDTH-1:0]};
        end else if (ma.inst.lbu) begin
            ma_dout = {{(DATA_WIDTH-B_WIDTH){1'b0}}, byte_word[B_WIDTH-1:0]};
        end else if (ma.inst.lh) begin
            ma_dout = {{(DATA_WIDTH/2){half_word[DATA_WIDTH/2-1]}},
                       half_word[DATA_WIDTH/2-1:0]};
        end else if (ma.inst.lhu) begin
            ma_dout = {{(DATA_WIDTH/2){1'b0}}, half_word[DATA_WIDTH/2-1:0]};
        end else if (ma.inst.lw) begin
            ma_dout = dout_1;
        end else begin
            ma_dout = '1;                        // not a load
        end
    end

    // one-hot decode keeps port 1 to a single direction per cycle
    always_comb begin
        if (!$isunknown({we_1, re_1})) begin
            a_rw_excl  : assert final (!(|we_1 && re_1))
                else $error("port 1 read and write in the same cycle");
        end
    end

endmodule : rip_memory_access

`default_nettype wire

//--- design/rip_result.sv
// ma stage register and load result register
// load_valid pulses once per completed load

`default_nettype none
`timescale 1ns/1ns

module rip_result (
    input  wire                               clk,
    input  wire                               rst,
    input  wire                               stall,
    input  wire rip_type::ex_stage_t          ex,
    output rip_type::ma_stage_t               ma,
    input  wire [rip_const::DATA_WIDTH-1:0]   ma_dout,
    output logic                              load_valid,
    output rip_type::load_result_t            load_result
);
    logic is_load;
    logic done;

    assign is_load = ma.inst.lb || ma.inst.lh || ma.inst.lw || ma.inst.lbu || ma.inst.lhu;
    assign done    = ma.valid && is_load && !stall;

    always_ff @(posedge clk) begin
        if (rst) begin
            ma.valid   <= 1'b0;
            load_valid <= 1'b0;
        end else begin
            if (!stall) begin
                ma.valid <= ex.valid;            // frozen while stalled
            end
            load_valid <= done;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            ma.inst <= ex.inst;
            ma.addr <= ex.addr;
            ma.rd   <= ex.rd;
        end
        if (done) begin
            load_result.data <= ma_dout;
            load_result.rd   <= ma.rd;
        end
    end

endmodule : rip_result

`default_nettype wire

//--- design/rip_type.sv
// decoded load/store flags
// execute and memory-access stage records, load result record

`default_nettype none

package rip_type;

    typedef struct packed {
        logic lb;
        logic lh;
        logic lw;
        logic lbu;
        logic lhu;
        logic sb;
        logic sh;
        logic sw;
    } inst_t;                                  // at most one flag set

    typedef struct packed {
        logic                              valid;
        inst_t                             inst;
        logic [rip_const::DATA_WIDTH-1:0]  addr;
        logic [rip_const::DATA_WIDTH-1:0]  din;   // store value
        logic [rip_const::RD_WIDTH-1:0]    rd;
    } ex_stage_t;

    typedef struct packed {
        logic                              valid;
        inst_t                             inst;
        logic [rip_const::DATA_WIDTH-1:0]  addr;
        logic [rip_const::RD_WIDTH-1:0]    rd;
    } ma_stage_t;

    typedef struct packed {
        logic [rip_const::DATA_WIDTH-1:0]  data;
        logic [rip_const::RD_WIDTH-1:0]    rd;
    } load_result_t;

endpackage : rip_type

`default_nettype wire

//--- rip_mem_subsys.f
design/rip_const.sv
design/rip_type.sv
design/rip_decode.sv
design/rip_execute.sv
design/rip_memory_access.sv
design/rip_dual_port_ram.sv
design/rip_result.sv
design/rip_mem_subsys.sv
test/rip_mem_subsys_tb.sv

//--- test/rip_mem_subsys_tb.sv
// directed testbench for the load/store memory subsystem
// byte-array reference memory, drive tasks and typed compare tasks
// word, byte, halfword, fetch, stall and no-result checks

`default_nettype none
`timescale 1ns/1ns

module rip_mem_subsys_tb;
    import rip_const::*;
    import rip_type::*;

    localparam int LOAD_TIMEOUT = 20;            // cycles

    logic                  clk;
    logic                  rst;
    logic                  cmd_valid;
    logic [DATA_WIDTH-1:0] cmd_inst;
    logic [DATA_WIDTH-1:0] cmd_rs1;
    logic [DATA_WIDTH-1:0] cmd_rs2;
    logic                  stall;
    logic                  if_ready;
    logic [DATA_WIDTH-1:0] pc;
    logic [DATA_WIDTH-1:0] if_dout;
    logic                  load_valid;
    load_result_t          load_result;

    logic [B_WIDTH-1:0]    ref_mem [MEM_WORDS*NUM_COL];   // byte-addressed model
    load_result_t          exp_q [$];

    rip_mem_subsys rip_mem_subsys_i (
        .clk         (clk),
        .rst         (rst),
        .cmd_valid   (cmd_valid),
        .cmd_inst    (cmd_inst),
        .cmd_rs1     (cmd_rs1),
        .cmd_rs2     (cmd_rs2),
        .stall       (stall),
        .if_ready    (if_ready),
        .pc          (pc),
        .if_dout     (if_dout),
        .load_valid  (load_valid),
        .load_result (load_result)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // reference model and compare tasks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic abort_run();
        $display("Simulation failed");
        $fatal(1, "stopped at first error");
    endtask

    function automatic logic [DATA_WIDTH-1:0] word_at(input logic [DATA_WIDTH-1:0] addr);
        logic [9:0] base;
        base = {addr[9:2], 2'b00};               // upper address bits wrap
        return {ref_mem[base+3], ref_mem[base+2], ref_mem[base+1], ref_mem[base]};
    endfunction

    function automatic logic [DATA_WIDTH-1:0] expected_load(input logic [2:0] f3,
                                                            input logic [DATA_WIDTH-1:0] addr);
        logic [DATA_WIDTH-1:0] word;
        logic [7:0]            b;
        logic [15:0]           h;
        int                    lo;
        word = word_at(addr);
        b    = word[addr[1:0]*B_WIDTH +: 8];
        lo   = addr[1] ? 2 : int'(addr[1:0]);   // offset 1 gives bits 23..8
        h    = word[lo*B_WIDTH +: 16];
        case (f3)
            F3_B:    return {{24{b[7]}}, b};
            F3_BU:   return {24'h0, b};
            F3_H:    return {{16{h[15]}}, h};
            F3_HU:   return {16'h0, h};
            default: return word;
        endcase
    endfunction

    task automatic check_load(input string what, input load_result_t got,
                              input load_result_t exp);
        if (got !== exp) begin
            $display("mismatch at %0t ns: %s got data=%h rd=%0d, expected data=%h rd=%0d",
                     $time, what, got.data, got.rd, exp.data, exp.rd);
            abort_run();
        end
    endtask

    task automatic check_word(input string what, input logic [DATA_WIDTH-1:0] got,
                              input logic [DATA_WIDTH-1:0] exp);
        if (got !== exp) begin
            $display("mismatch at %0t ns: %s got %h, expected %h", $time, what, got, exp);
            abort_run();
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // drive tasks, all return 1 ns after a rising edge
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic issue_cmd(input logic [DATA_WIDTH-1:0] inst,
                             input logic [DATA_WIDTH-1:0] rs1,
                             input logic [DATA_WIDTH-1:0] rs2);
        cmd_inst  = inst;
        cmd_rs1   = rs1;
        cmd_rs2   = rs2;
        cmd_valid = 1'b1;
        next_cycle();
        cmd_valid = 1'b0;                        // one-cycle strobe
    endtask

    task automatic do_store(input logic [2:0] f3, input logic [DATA_WIDTH-1:0] base,
                            input logic [11:0] imm, input logic [DATA_WIDTH-1:0] value);
        logic [DATA_WIDTH-1:0] addr;
        int                    n;
        addr = base + {{20{imm[11]}}, imm};
        n    = (f3 == F3_B) ? 1 : (f3 == F3_H) ? 2 : 4;
        for (int i = 0; i < n; i++) begin
            ref_mem[10'(addr[9:0] + i)] = value[i*B_WIDTH +: B_WIDTH];
        end
        issue_cmd({imm[11:5], 5'd2, 5'd1, f3, imm[4:0], OPC_STORE}, base, value);
    endtask

    task automatic do_load(input logic [2:0] f3, input logic [4:0] rd,
                           input logic [DATA_WIDTH-1:0] base, input logic [11:0] imm);
        logic [DATA_WIDTH-1:0] addr;
        load_result_t          exp;
        addr     = base + {{20{imm[11]}}, imm};
        exp.data = expected_load(f3, addr);
        exp.rd   = rd;
        exp_q.push_back(exp);
        issue_cmd({imm, 5'd1, f3, rd, OPC_LOAD}, base, '0);
    endtask

    task automatic wait_load_result();
        load_result_t exp;
        int           cycles;
        bit           seen;
        cycles = 0;
        seen   = 1'b0;
        if (exp_q.size() == 0) begin
            $display("no expected load result left to compare at %0t ns", $time);
            abort_run();
        end
        exp = exp_q.pop_front();
        while (!seen && cycles < LOAD_TIMEOUT) begin
            @(negedge clk);
            cycles++;
            seen = (load_valid === 1'b1);
        end
        if (!seen) begin
            $display("no load result arrived within %0d cycles at %0t ns", LOAD_TIMEOUT, $time);
            abort_run();
        end
        check_load("load_result", load_result, exp);
        next_cycle();
    endtask

    task automatic expect_no_load(input int cycles);
        for (int i = 0; i < cycles; i++) begin
            @(negedge clk);
            if (load_valid !== 1'b0) begin
                $display("load_valid raised at %0t ns with no load due", $time);
                abort_run();
            end
        end
        next_cycle();
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // directed tests
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic word_round_trip();
        logic [DATA_WIDTH-1:0] base;
        logic [11:0]           imm;
        logic [DATA_WIDTH-1:0] value;
        logic [4:0]            rd;
        for (int i = 0; i < 8; i++) begin
            base  = $urandom & 32'hffff_fffc;    // high bits wrap away
            imm   = 12'($urandom) & 12'hffc;
            value = $urandom;
            rd    = 5'($urandom);
            do_store(F3_W, base, imm, value);
            do_load(F3_W, rd, base, imm);
            wait_load_result();
        end
    endtask

    task automatic byte_access();
        logic [7:0] v;
        for (int o = 0; o < 4; o++) begin
            v = {(o % 2 == 0), 7'($urandom)};    // bit 7 set on even lanes
            do_store(F3_B, 32'h300, 12'(o), {24'($urandom), v});
        end
        for (int o = 0; o < 4; o++) begin
            do_load(F3_B, 5'(o + 1), 32'h300, 12'(o));
            wait_load_result();
            do_load(F3_BU, 5'(o + 16), 32'h300, 12'(o));
            wait_load_result();
        end
    endtask

    task automatic halfword_access();
        for (int pass = 0; pass < 2; pass++) begin
            do_store(F3_H, 32'h340, 12'h0, {16'($urandom), pass == 0, 15'($urandom)});
            do_store(F3_H, 32'h340, 12'h2, {16'($urandom), pass == 1, 15'($urandom)});
            for (int o = 0; o < 3; o++) begin
                do_load(F3_H, 5'(o + 3), 32'h340, 12'(o));
                wait_load_result();
                do_load(F3_HU, 5'(o + 20), 32'h340, 12'(o));
                wait_load_result();
            end
        end
    endtask

    task automatic fetch_check(input logic [DATA_WIDTH-1:0] addr);
        logic [DATA_WIDTH-1:0] exp;
        exp      = word_at(addr);
        pc       = addr;
        if_ready = 1'b1;
        next_cycle();
        if_ready = 1'b0;
        pc       = '0;
        check_word("if_dout", if_dout, exp);
        next_cycle();
        check_word("if_dout held", if_dout, exp);
    endtask

    task automatic stall_and_no_result();
        do_load(F3_W, 5'd7, 32'h300, 12'h0);
        do_load(F3_HU, 5'd9, 32'h340, 12'h1);
        stall = 1'b1;                            // both loads in flight
        expect_no_load(5);
        stall = 1'b0;
        wait_load_result();
        wait_load_result();
        expect_no_load(3);
        do_store(F3_W, 32'h380, 12'h0, $urandom);
        expect_no_load(4);
        issue_cmd(32'h0050_0093, '0, '0);        // addi x1, x0, 5
        expect_no_load(4);
        issue_cmd({12'h0, 5'd1, 3'b011, 5'd4, OPC_LOAD}, 32'h380, '0);  // reserved funct3
        expect_no_load(4);
        do_load(F3_W, 5'd12, 32'h380, 12'h0);
        wait_load_result();
    endtask

    initial begin
        void'($urandom(32'hdb6be275));
        rst       = 1'b1;
        cmd_valid = 1'b0;
        cmd_inst  = '0;
        cmd_rs1   = '0;
        cmd_rs2   = '0;
        stall     = 1'b0;
        if_ready  = 1'b0;
        pc        = '0;
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;
        expect_no_load(2);
        word_round_trip();
        byte_access();
        halfword_access();
        fetch_check(32'h0000_4343);              // wraps onto word 0x340
        fetch_check(32'h0000_0302);
        stall_and_no_result();
        $display("Simulation passed");
        $finish;
    end

endmodule : rip_mem_subsys_tb

`default_nettype wire
